// ==== source/lc_defs.svh ====
// link-to-cache bridge widths, cache geometry and queue depth
`ifndef LC_DEFS_SVH
`define LC_DEFS_SVH

// link side
`define LC_ADDR_W 16
`define LC_DATA_W 32
`define LC_X_W 4
`define LC_Y_W 3
`define LC_REG_W 5

// cache geometry
`define LC_SETS 4
`define LC_WAYS 2
`define LC_BLOCK_WORDS 4

`define LC_FIFO_ELS 4

// link word address minus the tag-op bit, plus byte offset
`define LC_CACHE_ADDR_W (`LC_ADDR_W - 1 + 2)
`define LC_ID_W (`LC_X_W + `LC_Y_W + 2 + `LC_REG_W)

`endif

// ==== source/lc_pkg.sv ====
// link-to-cache bridge types: link ops, cache opcodes, packets and request id
`default_nettype none

`include "lc_defs.svh"

package lc_pkg;

  typedef enum logic [1:0] {
    e_store    = 2'd0,
    e_load     = 2'd1,
    e_cache_op = 2'd2
  } req_op_e;

  // low bits of op_ex on a cache_op
  typedef enum logic [1:0] {
    e_afl    = 2'd0,
    e_aflinv = 2'd1,
    e_ainv   = 2'd2
  } cache_op_e;

  typedef enum logic [3:0] {
    LB     = 4'd0,
    LBU    = 4'd1,
    LH     = 4'd2,
    LHU    = 4'd3,
    LW     = 4'd4,
    SM     = 4'd5,
    TAGST  = 4'd6,
    TAGLA  = 4'd7,
    TAGFL  = 4'd8,
    AFL    = 4'd9,
    AFLINV = 4'd10,
    AINV   = 4'd11
  } cache_opcode_e;

  typedef enum logic [1:0] {
    e_ret_credit   = 2'd0,
    e_ret_int_wb   = 2'd1,
    e_ret_float_wb = 2'd2,
    e_ret_ifetch   = 2'd3
  } ret_type_e;

  // sits in the low bits of a load's data word
  typedef struct packed {
    logic       is_byte;
    logic       is_hex;
    logic       is_unsigned;
    logic       float_wb;
    logic       icache_fetch;
    logic [1:0] part_sel;
  } load_info_s;

  typedef struct packed {
    req_op_e               op;
    logic [3:0]            op_ex;
    logic [`LC_ADDR_W-1:0] addr;
    logic [`LC_DATA_W-1:0] data;
    logic [`LC_X_W-1:0]    src_x;
    logic [`LC_Y_W-1:0]    src_y;
    logic [`LC_REG_W-1:0]  reg_id;
  } link_req_s;

  typedef struct packed {
    ret_type_e             ret_type;
    logic [`LC_DATA_W-1:0] data;
    logic [`LC_REG_W-1:0]  reg_id;
    logic [`LC_X_W-1:0]    x;
    logic [`LC_Y_W-1:0]    y;
  } link_ret_s;

  typedef struct packed {
    logic [`LC_X_W-1:0]   src_x;
    logic [`LC_Y_W-1:0]   src_y;
    ret_type_e            ret_type;
    logic [`LC_REG_W-1:0] reg_id;
  } cache_id_s;

endpackage

`default_nettype wire

// ==== source/lc_fifo.sv ====
// small synchronous circular-buffer queue with a typed payload
`timescale 1ns/1ps
`default_nettype none

module lc_fifo #(
  parameter int  els_p  = 4,
  parameter type elem_t = logic
) (
  input  logic  clk_i,
  input  logic  reset_i,

  input  logic  v_i,
  input  elem_t data_i,
  output logic  ready_o,

  output logic  v_o,
  output elem_t data_o,
  input  logic  yumi_i
);

  localparam int ptr_w = (els_p > 1) ? $clog2(els_p) : 1;
  localparam int cnt_w = $clog2(els_p + 1);
  localparam logic [ptr_w-1:0] last_ptr = ptr_w'(els_p - 1);
  localparam logic [cnt_w-1:0] full_cnt = cnt_w'(els_p);

  elem_t            mem_r [els_p];
  logic [ptr_w-1:0] rd_ptr_r;
  logic [ptr_w-1:0] wr_ptr_r;
  logic [cnt_w-1:0] count_r;
  logic             push;
  logic             pop;

  // full refuses writes, even with a pop in the same cycle
  assign ready_o = (count_r != full_cnt);
  assign v_o     = (count_r != '0);
  assign data_o  = mem_r[rd_ptr_r];
  assign push    = v_i & ready_o;
  assign pop     = yumi_i & v_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_ptr_r <= '0;
      wr_ptr_r <= '0;
      count_r  <= '0;
    end else begin
      if (push) begin
        wr_ptr_r <= (wr_ptr_r == last_ptr) ? '0 : wr_ptr_r + 1'b1;
      end
      if (pop) begin
        rd_ptr_r <= (rd_ptr_r == last_ptr) ? '0 : rd_ptr_r + 1'b1;
      end
      if (push & ~pop) begin
        count_r <= count_r + 1'b1;
      end else if (pop & ~push) begin
        count_r <= count_r - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_r[wr_ptr_r] <= data_i;
    end
  end

endmodule

`default_nettype wire

// ==== source/lc_endpoint.sv ====
// link endpoint: queues incoming requests and drives queued returns onto the link
`timescale 1ns/1ps
`default_nettype none

`include "lc_defs.svh"

module lc_endpoint (
  input  logic                  clk_i,
  input  logic                  reset_i,

  input  logic                  req_v_i,
  input  lc_pkg::req_op_e       req_op_i,
  input  logic [3:0]            req_op_ex_i,
  input  logic [`LC_ADDR_W-1:0] req_addr_i,
  input  logic [`LC_DATA_W-1:0] req_data_i,
  input  logic [`LC_X_W-1:0]    req_src_x_i,
  input  logic [`LC_Y_W-1:0]    req_src_y_i,
  input  logic [`LC_REG_W-1:0]  req_reg_id_i,
  output logic                  req_ready_o,

  output logic                  ret_v_o,
  output lc_pkg::ret_type_e     ret_type_o,
  output logic [`LC_DATA_W-1:0] ret_data_o,
  output logic [`LC_REG_W-1:0]  ret_reg_id_o,
  output logic [`LC_X_W-1:0]    ret_x_o,
  output logic [`LC_Y_W-1:0]    ret_y_o,
  input  logic                  ret_ready_i,

  output lc_pkg::link_req_s     packet_o,
  output logic                  packet_v_o,
  input  logic                  packet_yumi_i,

  input  lc_pkg::link_ret_s     return_packet_i,
  input  logic                  return_packet_v_i,
  output logic                  return_packet_ready_o
);

  import lc_pkg::*;

  link_req_s req_in;
  link_ret_s ret_head;
  logic      ret_yumi;

  assign req_in.op     = req_op_i;
  assign req_in.op_ex  = req_op_ex_i;
  assign req_in.addr   = req_addr_i;
  assign req_in.data   = req_data_i;
  assign req_in.src_x  = req_src_x_i;
  assign req_in.src_y  = req_src_y_i;
  assign req_in.reg_id = req_reg_id_i;

  lc_fifo #(
    .els_p  (`LC_FIFO_ELS),
    .elem_t (link_req_s)
  ) req_fifo (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .v_i     (req_v_i),
    .data_i  (req_in),
    .ready_o (req_ready_o),
    .v_o     (packet_v_o),
    .data_o  (packet_o),
    .yumi_i  (packet_yumi_i)
  );

  // head is held on the link until the router takes it
  assign ret_yumi = ret_v_o & ret_ready_i;

  lc_fifo #(
    .els_p  (`LC_FIFO_ELS),
    .elem_t (link_ret_s)
  ) ret_fifo (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .v_i     (return_packet_v_i),
    .data_i  (return_packet_i),
    .ready_o (return_packet_ready_o),
    .v_o     (ret_v_o),
    .data_o  (ret_head),
    .yumi_i  (ret_yumi)
  );

  assign ret_type_o   = ret_head.ret_type;
  assign ret_data_o   = ret_head.data;
  assign ret_reg_id_o = ret_head.reg_id;
  assign ret_x_o      = ret_head.x;
  assign ret_y_o      = ret_head.y;

endmodule

`default_nettype wire

// ==== source/lc_link_to_cache.sv ====
// tag-clear sequencer and link-request to cache-packet translator
`timescale 1ns/1ps
`default_nettype none

`include "lc_defs.svh"

module lc_link_to_cache (
  input  logic                        clk_i,
  input  logic                        reset_i,

  input  lc_pkg::link_req_s           packet_i,
  input  logic                        packet_v_i,
  output logic                        packet_yumi_o,

  output lc_pkg::link_ret_s           return_packet_o,
  output logic                        return_packet_v_o,
  input  logic                        return_packet_ready_i,

  output logic                        cache_v_o,
  output lc_pkg::cache_opcode_e       cache_opcode_o,
  output logic [`LC_CACHE_ADDR_W-1:0] cache_addr_o,
  output logic [`LC_DATA_W-1:0]       cache_data_o,
  output logic [3:0]                  cache_mask_o,
  output logic [`LC_ID_W-1:0]         cache_id_o,
  input  logic                        cache_ready_i,

  input  logic                        cache_resp_v_i,
  input  logic [`LC_DATA_W-1:0]       cache_resp_data_i,
  input  logic [`LC_ID_W-1:0]         cache_resp_id_i,
  output logic                        cache_resp_yumi_o
);

  import lc_pkg::*;

  localparam int lg_sets_w = $clog2(`LC_SETS);
  localparam int lg_ways_w = $clog2(`LC_WAYS);
  localparam int idx_w     = lg_sets_w + lg_ways_w;
  localparam int byte_off_w = $clog2(`LC_DATA_W / 8);
  localparam int blk_off_w = $clog2(`LC_BLOCK_WORDS) + byte_off_w;
  localparam int pad_w     = `LC_CACHE_ADDR_W - idx_w - blk_off_w;
  localparam int cnt_w     = idx_w + 1;
  localparam logic [cnt_w-1:0] tag_total = cnt_w'(`LC_SETS * `LC_WAYS);

  typedef enum logic [1:0] {
    s_reset,
    s_clear_tag,
    s_ready
  } state_e;

  state_e           state_r;
  state_e           state_n;
  logic [cnt_w-1:0] tagst_sent_r;
  logic [cnt_w-1:0] tagst_sent_n;
  logic [cnt_w-1:0] tagst_recv_r;
  logic [cnt_w-1:0] tagst_recv_n;

  load_info_s load_info;
  cache_id_s  req_id;
  cache_id_s  resp_id;
  logic       no_load;

  assign load_info = load_info_s'(packet_i.data[$bits(load_info_s)-1:0]);
  assign resp_id   = cache_id_s'(cache_resp_id_i);
  assign no_load   = (packet_i.op == e_store) | (packet_i.op == e_cache_op);

  // id carries everything needed to route the reply back
  always_comb begin
    req_id.src_x  = packet_i.src_x;
    req_id.src_y  = packet_i.src_y;
    req_id.reg_id = packet_i.reg_id;
    if (no_load) begin
      req_id.ret_type = e_ret_credit;
    end else if (load_info.icache_fetch) begin
      req_id.ret_type = e_ret_ifetch;
    end else if (load_info.float_wb) begin
      req_id.ret_type = e_ret_float_wb;
    end else begin
      req_id.ret_type = e_ret_int_wb;
    end
  end

  assign return_packet_o.ret_type = resp_id.ret_type;
  assign return_packet_o.data     = cache_resp_data_i;
  assign return_packet_o.reg_id   = resp_id.reg_id;
  assign return_packet_o.x        = resp_id.src_x;
  assign return_packet_o.y        = resp_id.src_y;

  always_comb begin
    state_n           = state_r;
    tagst_sent_n      = tagst_sent_r;
    tagst_recv_n      = tagst_recv_r;
    cache_v_o         = 1'b0;
    cache_opcode_o    = TAGST;
    cache_addr_o      = '0;
    cache_data_o      = '0;
    cache_mask_o      = '0;
    cache_id_o        = '0;
    cache_resp_yumi_o = 1'b0;
    packet_yumi_o     = 1'b0;
    return_packet_v_o = 1'b0;

    case (state_r)
      s_reset: begin
        state_n = s_clear_tag;
      end

      s_clear_tag: begin
        // one tag-store per set and way
        cache_v_o    = (tagst_sent_r != tag_total);
        cache_addr_o = {{pad_w{1'b0}}, tagst_sent_r[idx_w-1:0], {blk_off_w{1'b0}}};
        if (cache_v_o & cache_ready_i) begin
          tagst_sent_n = tagst_sent_r + 1'b1;
        end
        // acks are dropped, nothing goes back to the link
        cache_resp_yumi_o = cache_resp_v_i;
        if (cache_resp_v_i) begin
          tagst_recv_n = tagst_recv_r + 1'b1;
        end
        if ((tagst_sent_r == tag_total) && (tagst_recv_r == tag_total)) begin
          state_n = s_ready;
        end
      end

      s_ready: begin
        cache_v_o     = packet_v_i;
        packet_yumi_o = packet_v_i & cache_ready_i;

        if (packet_i.addr[`LC_ADDR_W-1]) begin
          case (packet_i.op)
            e_store:    cache_opcode_o = TAGST;
            e_load:     cache_opcode_o = TAGLA;
            e_cache_op: cache_opcode_o = TAGFL;
            default:    cache_opcode_o = TAGLA;
          endcase
        end else if (packet_i.op == e_store) begin
          cache_opcode_o = SM;
        end else if (packet_i.op == e_cache_op) begin
          case (cache_op_e'(packet_i.op_ex[1:0]))
            e_afl:    cache_opcode_o = AFL;
            e_aflinv: cache_opcode_o = AFLINV;
            default:  cache_opcode_o = AINV;
          endcase
        end else if (load_info.is_byte) begin
          cache_opcode_o = load_info.is_unsigned ? LBU : LB;
        end else if (load_info.is_hex) begin
          cache_opcode_o = load_info.is_unsigned ? LHU : LH;
        end else begin
          cache_opcode_o = LW;
        end

        // word address from the link, byte select from load info
        cache_addr_o = {packet_i.addr[`LC_ADDR_W-2:0],
                        no_load ? 2'b00 : load_info.part_sel};
        cache_data_o = packet_i.data;
        cache_mask_o = packet_i.op_ex;
        cache_id_o   = req_id;

        return_packet_v_o = cache_resp_v_i & return_packet_ready_i;
        cache_resp_yumi_o = cache_resp_v_i & return_packet_ready_i;
      end

      default: begin
        state_n = s_reset;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r      <= s_reset;
      tagst_sent_r <= '0;
      tagst_recv_r <= '0;
    end else begin
      state_r      <= state_n;
      tagst_sent_r <= tagst_sent_n;
      tagst_recv_r <= tagst_recv_n;
    end
  end

endmodule

`default_nettype wire

// ==== source/lc_top.sv ====
// bridge top: link endpoint feeding the cache translator
`timescale 1ns/1ps
`default_nettype none

`include "lc_defs.svh"

module lc_top (
  input  logic                        clk_i,
  input  logic                        reset_i,

  input  logic                        req_v_i,
  input  lc_pkg::req_op_e             req_op_i,
  input  logic [3:0]                  req_op_ex_i,
  input  logic [`LC_ADDR_W-1:0]       req_addr_i,
  input  logic [`LC_DATA_W-1:0]       req_data_i,
  input  logic [`LC_X_W-1:0]          req_src_x_i,
  input  logic [`LC_Y_W-1:0]          req_src_y_i,
  input  logic [`LC_REG_W-1:0]        req_reg_id_i,
  output logic                        req_ready_o,

  output logic                        ret_v_o,
  output lc_pkg::ret_type_e           ret_type_o,
  output logic [`LC_DATA_W-1:0]       ret_data_o,
  output logic [`LC_REG_W-1:0]        ret_reg_id_o,
  output logic [`LC_X_W-1:0]          ret_x_o,
  output logic [`LC_Y_W-1:0]          ret_y_o,
  input  logic                        ret_ready_i,

  output logic                        cache_v_o,
  output lc_pkg::cache_opcode_e       cache_opcode_o,
  output logic [`LC_CACHE_ADDR_W-1:0] cache_addr_o,
  output logic [`LC_DATA_W-1:0]       cache_data_o,
  output logic [3:0]                  cache_mask_o,
  output logic [`LC_ID_W-1:0]         cache_id_o,
  input  logic                        cache_ready_i,

  input  logic                        cache_resp_v_i,
  input  logic [`LC_DATA_W-1:0]       cache_resp_data_i,
  input  logic [`LC_ID_W-1:0]         cache_resp_id_i,
  output logic                        cache_resp_yumi_o
);

  import lc_pkg::*;

  link_req_s packet;
  logic      packet_v;
  logic      packet_yumi;
  link_ret_s return_packet;
  logic      return_packet_v;
  logic      return_packet_ready;

  lc_endpoint ep (
    .clk_i                 (clk_i),
    .reset_i               (reset_i),
    .req_v_i               (req_v_i),
    .req_op_i              (req_op_i),
    .req_op_ex_i           (req_op_ex_i),
    .req_addr_i            (req_addr_i),
    .req_data_i            (req_data_i),
    .req_src_x_i           (req_src_x_i),
    .req_src_y_i           (req_src_y_i),
    .req_reg_id_i          (req_reg_id_i),
    .req_ready_o           (req_ready_o),
    .ret_v_o               (ret_v_o),
    .ret_type_o            (ret_type_o),
    .ret_data_o            (ret_data_o),
    .ret_reg_id_o          (ret_reg_id_o),
    .ret_x_o               (ret_x_o),
    .ret_y_o               (ret_y_o),
    .ret_ready_i           (ret_ready_i),
    .packet_o              (packet),
    .packet_v_o            (packet_v),
    .packet_yumi_i         (packet_yumi),
    .return_packet_i       (return_packet),
    .return_packet_v_i     (return_packet_v),
    .return_packet_ready_o (return_packet_ready)
  );

  lc_link_to_cache l2c (
    .clk_i                 (clk_i),
    .reset_i               (reset_i),
    .packet_i              (packet),
    .packet_v_i            (packet_v),
    .packet_yumi_o         (packet_yumi),
    .return_packet_o       (return_packet),
    .return_packet_v_o     (return_packet_v),
    .return_packet_ready_i (return_packet_ready),
    .cache_v_o             (cache_v_o),
    .cache_opcode_o        (cache_opcode_o),
    .cache_addr_o          (cache_addr_o),
    .cache_data_o          (cache_data_o),
    .cache_mask_o          (cache_mask_o),
    .cache_id_o            (cache_id_o),
    .cache_ready_i         (cache_ready_i),
    .cache_resp_v_i        (cache_resp_v_i),
    .cache_resp_data_i     (cache_resp_data_i),
    .cache_resp_id_i       (cache_resp_id_i),
    .cache_resp_yumi_o     (cache_resp_yumi_o)
  );

endmodule

`default_nettype wire

// ==== dv/lc_props.sv ====
// bridge protocol checks: stalled packets hold, outputs quiet after reset
`timescale 1ns/1ps
`default_nettype none

`include "lc_defs.svh"

module lc_props (
  input logic                        clk_i,
  input logic                        reset_i,
  input logic                        cache_v_o,
  input logic [3:0]                  cache_opcode_o,
  input logic [`LC_CACHE_ADDR_W-1:0] cache_addr_o,
  input logic [`LC_DATA_W-1:0]       cache_data_o,
  input logic [3:0]                  cache_mask_o,
  input logic [`LC_ID_W-1:0]         cache_id_o,
  input logic                        cache_ready_i,
  input logic                        cache_resp_yumi_o,
  input logic                        ret_v_o,
  input logic [1:0]                  ret_type_o,
  input logic [`LC_DATA_W-1:0]       ret_data_o,
  input logic [`LC_REG_W-1:0]        ret_reg_id_o,
  input logic [`LC_X_W-1:0]          ret_x_o,
  input logic [`LC_Y_W-1:0]          ret_y_o,
  input logic                        ret_ready_i
);

  cache_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    (cache_v_o && !cache_ready_i) |=> (cache_v_o && $stable({cache_opcode_o,
      cache_addr_o, cache_data_o, cache_mask_o, cache_id_o})))
    else $error("cache packet changed while stalled");

  ret_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    (ret_v_o && !ret_ready_i) |=> (ret_v_o && $stable({ret_type_o, ret_data_o,
      ret_reg_id_o, ret_x_o, ret_y_o})))
    else $error("return packet changed while stalled");

  quiet_after_reset: assert property (@(posedge clk_i)
    $fell(reset_i) |-> (!cache_v_o && !ret_v_o && !cache_resp_yumi_o))
    else $error("valid or yumi high right after reset");

endmodule

bind lc_top lc_props props (.*);

`default_nettype wire

// ==== dv/lc_tb.sv ====
// directed testbench for the link-to-cache bridge with a simple cache model
`timescale 1ns/1ps
`default_nettype none

`include "lc_defs.svh"

module lc_tb;

  import lc_pkg::*;

  localparam int wait_limit = 200;

  logic                        clk_i;
  logic                        reset_i;
  logic                        req_v_i;
  req_op_e                     req_op_i;
  logic [3:0]                  req_op_ex_i;
  logic [`LC_ADDR_W-1:0]       req_addr_i;
  logic [`LC_DATA_W-1:0]       req_data_i;
  logic [`LC_X_W-1:0]          req_src_x_i;
  logic [`LC_Y_W-1:0]          req_src_y_i;
  logic [`LC_REG_W-1:0]        req_reg_id_i;
  logic                        req_ready_o;
  logic                        ret_v_o;
  ret_type_e                   ret_type_o;
  logic [`LC_DATA_W-1:0]       ret_data_o;
  logic [`LC_REG_W-1:0]        ret_reg_id_o;
  logic [`LC_X_W-1:0]          ret_x_o;
  logic [`LC_Y_W-1:0]          ret_y_o;
  logic                        ret_ready_i;
  logic                        cache_v_o;
  cache_opcode_e               cache_opcode_o;
  logic [`LC_CACHE_ADDR_W-1:0] cache_addr_o;
  logic [`LC_DATA_W-1:0]       cache_data_o;
  logic [3:0]                  cache_mask_o;
  logic [`LC_ID_W-1:0]         cache_id_o;
  logic                        cache_ready_i;
  logic                        cache_resp_v_i;
  logic [`LC_DATA_W-1:0]       cache_resp_data_i;
  logic [`LC_ID_W-1:0]         cache_resp_id_i;
  logic                        cache_resp_yumi_o;

  int errors;
  int seed;

  lc_top UUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  task automatic check_field(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s: got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int start_errors);
    $display("%s: %0d errors", name, errors - start_errors);
  endtask

  // expected cache opcode for a link request
  function automatic cache_opcode_e exp_opcode(input req_op_e op, input logic [3:0] op_ex,
                                               input logic [15:0] addr,
                                               input logic [31:0] data);
    load_info_s li;
    li = load_info_s'(data[6:0]);
    if (addr[15]) begin
      if (op == e_store) return TAGST;
      if (op == e_load) return TAGLA;
      return TAGFL;
    end
    if (op == e_store) return SM;
    if (op == e_cache_op) begin
      if (op_ex[1:0] == 2'd0) return AFL;
      if (op_ex[1:0] == 2'd1) return AFLINV;
      return AINV;
    end
    if (li.is_byte) return li.is_unsigned ? LBU : LB;
    if (li.is_hex) return li.is_unsigned ? LHU : LH;
    return LW;
  endfunction

  function automatic ret_type_e exp_ret_type(input req_op_e op, input logic [31:0] data);
    load_info_s li;
    li = load_info_s'(data[6:0]);
    if (op != e_load) return e_ret_credit;
    if (li.icache_fetch) return e_ret_ifetch;
    if (li.float_wb) return e_ret_float_wb;
    return e_ret_int_wb;
  endfunction

  task automatic send_req(input req_op_e op, input logic [3:0] op_ex,
                          input logic [15:0] addr, input logic [31:0] data,
                          input logic [3:0] x, input logic [2:0] y, input logic [4:0] rg);
    int n;
    req_v_i      = 1'b1;
    req_op_i     = op;
    req_op_ex_i  = op_ex;
    req_addr_i   = addr;
    req_data_i   = data;
    req_src_x_i  = x;
    req_src_y_i  = y;
    req_reg_id_i = rg;
    n = 0;
    while (!req_ready_o && n < wait_limit) begin
      @(negedge clk_i);
      n++;
    end
    if (!req_ready_o) begin
      $display("timeout: link request was never accepted at %0t", $time);
      errors++;
    end
    @(negedge clk_i);
    req_v_i = 1'b0;
  endtask

  // cache model takes one packet
  task automatic get_cache_req(output cache_opcode_e opc, output logic [16:0] addr,
                               output logic [31:0] data, output logic [3:0] mask,
                               output logic [13:0] id);
    int n;
    n = 0;
    while (!cache_v_o && n < wait_limit) begin
      @(negedge clk_i);
      n++;
    end
    if (!cache_v_o) begin
      $display("timeout: no cache request arrived at %0t", $time);
      errors++;
    end
    opc  = cache_opcode_o;
    addr = cache_addr_o;
    data = cache_data_o;
    mask = cache_mask_o;
    id   = cache_id_o;
    cache_ready_i = 1'b1;
    @(negedge clk_i);
    cache_ready_i = 1'b0;
  endtask

  task automatic present_resp(input logic [31:0] data, input logic [13:0] id);
    cache_resp_v_i    = 1'b1;
    cache_resp_data_i = data;
    cache_resp_id_i   = id;
  endtask

  task automatic wait_resp_taken();
    int n;
    n = 0;
    #10;
    while (!cache_resp_yumi_o && n < wait_limit) begin
      @(negedge clk_i);
      #10;
      n++;
    end
    if (!cache_resp_yumi_o) begin
      $display("timeout: cache response was never consumed at %0t", $time);
      errors++;
    end
    @(negedge clk_i);
    cache_resp_v_i = 1'b0;
  endtask

  task automatic send_resp(input logic [31:0] data, input logic [13:0] id);
    present_resp(data, id);
    wait_resp_taken();
  endtask

  task automatic get_ret(output ret_type_e rt, output logic [31:0] data,
                         output logic [4:0] rg, output logic [3:0] x, output logic [2:0] y);
    int n;
    n = 0;
    while (!ret_v_o && n < wait_limit) begin
      @(negedge clk_i);
      n++;
    end
    if (!ret_v_o) begin
      $display("timeout: no return packet appeared at %0t", $time);
      errors++;
    end
    rt   = ret_type_o;
    data = ret_data_o;
    rg   = ret_reg_id_o;
    x    = ret_x_o;
    y    = ret_y_o;
    ret_ready_i = 1'b1;
    @(negedge clk_i);
    ret_ready_i = 1'b0;
  endtask

  // one request through the cache model and back to the link
  task automatic do_txn(input req_op_e op, input logic [3:0] op_ex,
                        input logic [15:0] addr, input logic [31:0] data);
    cache_opcode_e opc;
    logic [16:0]   caddr;
    logic [31:0]   cdata;
    logic [3:0]    cmask;
    logic [13:0]   cid;
    cache_id_s     id;
    logic [31:0]   rnd;
    logic [31:0]   rdata;
    ret_type_e     rt;
    logic [31:0]   rd;
    logic [4:0]    rr;
    logic [3:0]    rx;
    logic [2:0]    ry;
    rnd = $random(seed);
    send_req(op, op_ex, addr, data, rnd[3:0], rnd[6:4], rnd[11:7]);
    get_cache_req(opc, caddr, cdata, cmask, cid);
    check_field("cache_opcode_o", 32'(opc), 32'(exp_opcode(op, op_ex, addr, data)));
    check_field("cache_addr_o", 32'(caddr),
                32'({addr[14:0], (op == e_load) ? data[1:0] : 2'b00}));
    check_field("cache_data_o", cdata, data);
    check_field("cache_mask_o", 32'(cmask), 32'(op_ex));
    id = cache_id_s'(cid);
    check_field("cache_id_o.ret_type", 32'(id.ret_type), 32'(exp_ret_type(op, data)));
    check_field("cache_id_o.src_x", 32'(id.src_x), 32'(rnd[3:0]));
    check_field("cache_id_o.src_y", 32'(id.src_y), 32'(rnd[6:4]));
    check_field("cache_id_o.reg_id", 32'(id.reg_id), 32'(rnd[11:7]));
    rdata = $random(seed);
    send_resp(rdata, cid);
    get_ret(rt, rd, rr, rx, ry);
    check_field("ret_type_o", 32'(rt), 32'(exp_ret_type(op, data)));
    check_field("ret_data_o", rd, rdata);
    check_field("ret_reg_id_o", 32'(rr), 32'(rnd[11:7]));
    check_field("ret_x_o", 32'(rx), 32'(rnd[3:0]));
    check_field("ret_y_o", 32'(ry), 32'(rnd[6:4]));
  endtask

  task automatic test_tag_clear();
    int            start;
    cache_opcode_e opc;
    logic [16:0]   caddr;
    logic [31:0]   cdata;
    logic [3:0]    cmask;
    logic [13:0]   cid;
    start = errors;
    check_field("cache_v_o", 32'(cache_v_o), 32'd0);
    check_field("ret_v_o", 32'(ret_v_o), 32'd0);
    check_field("cache_resp_yumi_o", 32'(cache_resp_yumi_o), 32'd0);
    check_field("req_ready_o", 32'(req_ready_o), 32'd1);
    for (int i = 0; i < `LC_SETS * `LC_WAYS; i++) begin
      get_cache_req(opc, caddr, cdata, cmask, cid);
      check_field("cache_opcode_o", 32'(opc), 32'(TAGST));
      check_field("cache_addr_o", 32'(caddr), 32'(i * 16));
      check_field("cache_data_o", cdata, 32'd0);
      check_field("cache_mask_o", 32'(cmask), 32'd0);
      send_resp(32'd0, cid);
    end
    // nothing more once the tags are clear and the link is idle
    repeat (10) begin
      @(negedge clk_i);
      check_field("cache_v_o", 32'(cache_v_o), 32'd0);
      check_field("ret_v_o", 32'(ret_v_o), 32'd0);
    end
    report_test("tag clear", start);
  endtask

  task automatic test_loads();
    int          start;
    logic [31:0] rnd;
    start = errors;
    for (int i = 0; i < 128; i++) begin
      rnd = $random(seed);
      do_txn(e_load, 4'h0, {1'b0, rnd[22:8]}, {rnd[31:7], 7'(i)});
    end
    report_test("load translation", start);
  endtask

  task automatic test_stores_and_maint();
    int          start;
    logic [31:0] rnd;
    start = errors;
    rnd = $random(seed);
    do_txn(e_store, rnd[3:0], {1'b0, rnd[18:4]}, $random(seed));
    for (int k = 0; k < 3; k++) begin
      rnd = $random(seed);
      do_txn(e_cache_op, {2'b00, 2'(k)}, {1'b0, rnd[14:0]}, {rnd[31:2], 2'b11});
    end
    report_test("stores and maintenance", start);
  endtask

  task automatic test_tag_ops();
    int          start;
    logic [31:0] rnd;
    start = errors;
    rnd = $random(seed);
    do_txn(e_store, 4'hf, {1'b1, rnd[14:0]}, $random(seed));
    do_txn(e_load, 4'h0, {1'b1, rnd[30:16]}, $random(seed));
    do_txn(e_cache_op, 4'h1, {1'b1, rnd[22:8]}, $random(seed));
    report_test("tag operations", start);
  endtask

  task automatic test_backpressure();
    int            start;
    int            order [5];
    logic [13:0]   ids [5];
    logic [31:0]   rdata [5];
    cache_opcode_e opc;
    logic [16:0]   caddr;
    logic [31:0]   cdata;
    logic [3:0]    cmask;
    cache_id_s     bid;
    ret_type_e     rt;
    logic [31:0]   rd;
    logic [4:0]    rr;
    logic [3:0]    rx;
    logic [2:0]    ry;
    start = errors;
    order = '{2, 0, 3, 1, 4};
    for (int k = 0; k < 4; k++) begin
      send_req(e_load, 4'h0, 16'(k * 4), 32'd0, 4'(k), 3'd5, 5'(k));
    end
    check_field("req_ready_o", 32'(req_ready_o), 32'd0);
    for (int k = 0; k < 5; k++) begin
      if (k == 4) begin
        send_req(e_load, 4'h0, 16'd16, 32'd0, 4'd4, 3'd5, 5'd4);
      end
      get_cache_req(opc, caddr, cdata, cmask, ids[k]);
      check_field("cache_opcode_o", 32'(opc), 32'(LW));
      check_field("cache_addr_o", 32'(caddr), 32'(k * 16));
      check_field("cache_data_o", cdata, 32'd0);
      check_field("cache_mask_o", 32'(cmask), 32'd0);
      bid = cache_id_s'(ids[k]);
      check_field("cache_id_o.reg_id", 32'(bid.reg_id), 32'(k));
    end
    // answers out of order while the link refuses returns
    for (int j = 0; j < 5; j++) begin
      rdata[j] = $random(seed);
    end
    for (int j = 0; j < 4; j++) begin
      send_resp(rdata[order[j]], ids[order[j]]);
    end
    present_resp(rdata[4], ids[4]);
    repeat (3) begin
      #10;
      check_field("cache_resp_yumi_o", 32'(cache_resp_yumi_o), 32'd0);
      check_field("ret_v_o", 32'(ret_v_o), 32'd1);
      @(negedge clk_i);
    end
    for (int j = 0; j < 5; j++) begin
      get_ret(rt, rd, rr, rx, ry);
      if (j == 0) begin
        wait_resp_taken();
      end
      check_field("ret_type_o", 32'(rt), 32'(e_ret_int_wb));
      check_field("ret_data_o", rd, rdata[order[j]]);
      check_field("ret_reg_id_o", 32'(rr), 32'(order[j]));
      check_field("ret_x_o", 32'(rx), 32'(order[j]));
      check_field("ret_y_o", 32'(ry), 32'd5);
    end
    repeat (4) begin
      @(negedge clk_i);
      check_field("ret_v_o", 32'(ret_v_o), 32'd0);
    end
    report_test("back-pressure and ordering", start);
  endtask

  initial begin
    errors            = 0;
    seed              = 76840;
    reset_i           = 1'b1;
    req_v_i           = 1'b0;
    req_op_i          = e_store;
    req_op_ex_i       = '0;
    req_addr_i        = '0;
    req_data_i        = '0;
    req_src_x_i       = '0;
    req_src_y_i       = '0;
    req_reg_id_i      = '0;
    ret_ready_i       = 1'b0;
    cache_ready_i     = 1'b0;
    cache_resp_v_i    = 1'b0;
    cache_resp_data_i = '0;
    cache_resp_id_i   = '0;
    repeat (16) @(negedge clk_i);
    reset_i = 1'b0;

    test_tag_clear();
    test_loads();
    test_stores_and_maint();
    test_tag_ops();
    test_backpressure();

    $display("5 tests run, %0d errors", errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+source
source/lc_pkg.sv
source/lc_fifo.sv
source/lc_endpoint.sv
source/lc_link_to_cache.sv
source/lc_top.sv
dv/lc_props.sv
dv/lc_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the bridge testbench with Verilator, run it and look for the pass line
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert -f src.f --top-module lc_tb -o lc_sim; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/lc_sim)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -q "All tests passed"; then
  exit 0
else
  echo "pass line not found in simulation output"
  exit 1
fi
